/* list.f */
source/cache_pkg.sv
source/store_lane_gen.sv
source/tag_store.sv
source/lru_tracker.sv
source/line_store.sv
source/data_cache.sv
tb/tb_clock_gen.sv
tb/data_cache_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module data_cache_tb \
    -Mdir obj_dir -o data_cache_sim

./obj_dir/data_cache_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Run failed, see sim.log"
    exit 1
fi
echo "Run passed"
exit 0

/* source/cache_pkg.sv */
package cache_pkg;

    // ----------------------------------------
    // Geometry.
    // ----------------------------------------
    localparam int WAYS       = 4;
    localparam int WAY_W      = 2;
    localparam int ADDR_W     = 64;
    localparam int REG_W      = 64;
    localparam int LINE_BYTES = 64;
    localparam int LINE_W     = 512;
    localparam int LINE_WORDS = 16;
    localparam int WORD_OFS_W = 4;
    localparam int BYTE_OFS_W = 2;

    // Full offset within a line.
    localparam int OFS_W = WORD_OFS_W + BYTE_OFS_W;

    // ----------------------------------------
    // Types.
    // ----------------------------------------

    // RISC-V store width.
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } store_size_e;

    // Single-cycle command strobes from the controller.
    typedef struct packed {
        logic store_en;
        logic refill_en;
        logic touch_en;
    } cache_cmd_t;

    // One cache line, seen as bytes for stores and as words for loads.
    typedef union packed {
        logic [LINE_BYTES-1:0][7:0] bytes;
        logic [LINE_WORDS-1:0][31:0] words;
    } line_t;

endpackage

/* source/data_cache.sv */
`timescale 1ns/1ps

module data_cache #(
    parameter int SET_COUNT = 16
) (
    input  logic                             clk,
    input  logic                             arstn,
    input  cache_pkg::cache_cmd_t            i_cmd,
    input  logic [cache_pkg::ADDR_W-1:0]     i_addr,
    input  cache_pkg::store_size_e           i_size,
    input  logic [cache_pkg::REG_W-1:0]      i_wdata,
    input  cache_pkg::line_t                 i_line,
    output logic                             o_hit,
    output logic [cache_pkg::REG_W-1:0]      o_rdata,
    output cache_pkg::line_t                 o_victim_line,
    output logic                             o_victim_dirty,
    output logic [cache_pkg::ADDR_W-1:0]     o_wb_addr,
    output logic                             o_store_misaligned
);

    localparam int IDX_W = $clog2(SET_COUNT);
    localparam int TAG_W = cache_pkg::ADDR_W - IDX_W - cache_pkg::OFS_W;

    logic [TAG_W-1:0]                   s_tag;
    logic [IDX_W-1:0]                   s_index;
    logic [cache_pkg::OFS_W-1:0]        s_offset;
    logic [cache_pkg::WORD_OFS_W-1:0]   s_word_ofs;

    logic [cache_pkg::WAY_W-1:0]        s_hit_way;
    logic [cache_pkg::WAY_W-1:0]        s_victim_way;
    logic [cache_pkg::WAY_W-1:0]        s_active_way;
    logic [cache_pkg::LINE_BYTES-1:0]   s_byte_mask;
    logic [cache_pkg::LINE_W-1:0]       s_lane_data;

    // ----------------------------------------
    // Address split.
    // ----------------------------------------
    assign s_tag      = i_addr[cache_pkg::ADDR_W-1 -: TAG_W];
    assign s_index    = i_addr[cache_pkg::OFS_W +: IDX_W];
    assign s_offset   = i_addr[cache_pkg::OFS_W-1:0];
    assign s_word_ofs = s_offset[cache_pkg::OFS_W-1:cache_pkg::BYTE_OFS_W];

    // Hit way on a hit, otherwise the replacement candidate.
    assign s_active_way = o_hit ? s_hit_way : s_victim_way;

    store_lane_gen u_lanes (
        .i_size       (i_size),
        .i_offset     (s_offset),
        .i_wdata      (i_wdata),
        .o_misaligned (o_store_misaligned),
        .o_byte_mask  (s_byte_mask),
        .o_lane_data  (s_lane_data)
    );

    tag_store #(.SET_COUNT(SET_COUNT)) u_tags (
        .clk            (clk),
        .arstn          (arstn),
        .i_index        (s_index),
        .i_tag          (s_tag),
        .i_store_en     (i_cmd.store_en),
        .i_refill_en    (i_cmd.refill_en),
        .i_victim_way   (s_victim_way),
        .o_hit          (o_hit),
        .o_hit_way      (s_hit_way),
        .o_victim_dirty (o_victim_dirty),
        .o_wb_addr      (o_wb_addr)
    );

    lru_tracker #(.SET_COUNT(SET_COUNT)) u_lru (
        .clk          (clk),
        .arstn        (arstn),
        .i_index      (s_index),
        .i_touch_en   (i_cmd.touch_en),
        .i_way        (s_active_way),
        .o_victim_way (s_victim_way)
    );

    line_store #(.SET_COUNT(SET_COUNT)) u_lines (
        .clk           (clk),
        .i_index       (s_index),
        .i_way         (s_active_way),
        .i_victim_way  (s_victim_way),
        .i_word_ofs    (s_word_ofs),
        .i_store_en    (i_cmd.store_en),
        .i_refill_en   (i_cmd.refill_en),
        .i_byte_mask   (s_byte_mask),
        .i_lane_data   (s_lane_data),
        .i_line        (i_line),
        .o_rdata       (o_rdata),
        .o_victim_line (o_victim_line)
    );

    // ----------------------------------------
    // Command checks.
    // ----------------------------------------
    store_aligned: assert property (
        @(posedge clk) disable iff (~arstn) i_cmd.store_en |-> ~o_store_misaligned
    ) else $error("Store issued to a misaligned address.");

    store_refill_excl: assert property (
        @(posedge clk) disable iff (~arstn) ~(i_cmd.store_en & i_cmd.refill_en)
    ) else $error("Store and refill issued together.");

    refill_on_miss: assert property (
        @(posedge clk) disable iff (~arstn) i_cmd.refill_en |-> ~o_hit
    ) else $error("Refill issued on a hit.");

endmodule

/* source/line_store.sv */
`timescale 1ns/1ps

module line_store #(
    parameter int SET_COUNT = 16,
    localparam int IDX_W = $clog2(SET_COUNT)
) (
    input  logic                               clk,
    input  logic [IDX_W-1:0]                   i_index,
    input  logic [cache_pkg::WAY_W-1:0]        i_way,
    input  logic [cache_pkg::WAY_W-1:0]        i_victim_way,
    input  logic [cache_pkg::WORD_OFS_W-1:0]   i_word_ofs,
    input  logic                               i_store_en,
    input  logic                               i_refill_en,
    input  logic [cache_pkg::LINE_BYTES-1:0]   i_byte_mask,
    input  logic [cache_pkg::LINE_W-1:0]       i_lane_data,
    input  cache_pkg::line_t                   i_line,
    output logic [cache_pkg::REG_W-1:0]        o_rdata,
    output cache_pkg::line_t                   o_victim_line
);

    cache_pkg::line_t data_mem [SET_COUNT][cache_pkg::WAYS];

    cache_pkg::line_t                   s_cur_line;
    cache_pkg::line_t                   s_merged;
    logic [cache_pkg::WORD_OFS_W-1:0]   s_next_ofs;
    logic [31:0]                        s_lo_word;
    logic [31:0]                        s_hi_word;

    assign s_cur_line    = data_mem[i_index][i_way];
    assign o_victim_line = data_mem[i_index][i_victim_way];

    // ----------------------------------------
    // Read window.
    // ----------------------------------------
    assign s_next_ofs = i_word_ofs + 1'b1;
    assign s_lo_word  = s_cur_line.words[i_word_ofs];

    // Past the end of the line.
    assign s_hi_word = (i_word_ofs == '1) ? 32'h0 : s_cur_line.words[s_next_ofs];

    assign o_rdata = {s_hi_word, s_lo_word};

    // ----------------------------------------
    // Writes.
    // ----------------------------------------

    // Masked bytes replaced, the rest kept.
    always_comb begin
        s_merged = s_cur_line;
        for (int b = 0; b < cache_pkg::LINE_BYTES; b++) begin
            if (i_byte_mask[b]) begin
                s_merged.bytes[b] = i_lane_data[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_store_en) begin
            data_mem[i_index][i_way] <= s_merged;
        end else if (i_refill_en) begin
            data_mem[i_index][i_victim_way] <= i_line;
        end
    end

endmodule

/* source/lru_tracker.sv */
`timescale 1ns/1ps

module lru_tracker #(
    parameter int SET_COUNT = 16,
    localparam int IDX_W = $clog2(SET_COUNT)
) (
    input  logic                          clk,
    input  logic                          arstn,
    input  logic [IDX_W-1:0]              i_index,
    input  logic                          i_touch_en,
    input  logic [cache_pkg::WAY_W-1:0]   i_way,
    output logic [cache_pkg::WAY_W-1:0]   o_victim_way
);

    // Age 0 is least recently used, WAYS-1 most recent.
    logic [cache_pkg::WAY_W-1:0] age_q [SET_COUNT][cache_pkg::WAYS];

    logic [cache_pkg::WAYS-1:0] s_age_seen;

    // ----------------------------------------
    // Victim choice.
    // ----------------------------------------
    always_comb begin
        o_victim_way = '0;
        for (int w = cache_pkg::WAYS - 1; w >= 0; w--) begin
            if (age_q[i_index][w] == '0) begin
                o_victim_way = cache_pkg::WAY_W'(w);
            end
        end
    end

    // ----------------------------------------
    // Age update.
    // ----------------------------------------
    always_ff @(posedge clk or negedge arstn) begin
        if (~arstn) begin
            for (int s = 0; s < SET_COUNT; s++) begin
                for (int w = 0; w < cache_pkg::WAYS; w++) begin
                    age_q[s][w] <= cache_pkg::WAY_W'(w);
                end
            end
        end else if (i_touch_en) begin
            for (int w = 0; w < cache_pkg::WAYS; w++) begin
                if (age_q[i_index][w] > age_q[i_index][i_way]) begin
                    age_q[i_index][w] <= age_q[i_index][w] - 1'b1;
                end
            end
            age_q[i_index][i_way] <= cache_pkg::WAY_W'(cache_pkg::WAYS - 1);
        end
    end

    // Each age value shows up exactly once.
    always_comb begin
        s_age_seen = '0;
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            s_age_seen[age_q[i_index][w]] = 1'b1;
        end
    end

    ages_distinct: assert property (
        @(posedge clk) disable iff (~arstn) &s_age_seen
    ) else $error("LRU ages of the set are not a permutation.");

endmodule

/* source/store_lane_gen.sv */
`timescale 1ns/1ps

module store_lane_gen (
    input  cache_pkg::store_size_e             i_size,
    input  logic [cache_pkg::OFS_W-1:0]        i_offset,
    input  logic [cache_pkg::REG_W-1:0]        i_wdata,
    output logic                               o_misaligned,
    output logic [cache_pkg::LINE_BYTES-1:0]   o_byte_mask,
    output logic [cache_pkg::LINE_W-1:0]       o_lane_data
);

    logic [cache_pkg::BYTE_OFS_W-1:0] s_byte_ofs;
    logic                             s_word_ofs_lsb;
    logic                             s_mis_h;
    logic                             s_mis_w;
    logic                             s_mis_d;
    logic [cache_pkg::LINE_BYTES-1:0] s_base_mask;

    assign s_byte_ofs     = i_offset[cache_pkg::BYTE_OFS_W-1:0];
    assign s_word_ofs_lsb = i_offset[cache_pkg::BYTE_OFS_W];

    // ----------------------------------------
    // Misalignment.
    // ----------------------------------------
    assign s_mis_h = s_byte_ofs[0];
    assign s_mis_w = |s_byte_ofs;
    assign s_mis_d = s_mis_w | s_word_ofs_lsb;

    always_comb begin
        case (i_size)
            cache_pkg::SIZE_H: o_misaligned = s_mis_h;
            cache_pkg::SIZE_W: o_misaligned = s_mis_w;
            cache_pkg::SIZE_D: o_misaligned = s_mis_d;
            default:           o_misaligned = 1'b0;
        endcase
    end

    // ----------------------------------------
    // Byte mask and lane data.
    // ----------------------------------------

    // Mask of the store width, placed at byte zero.
    always_comb begin
        case (i_size)
            cache_pkg::SIZE_H: s_base_mask = cache_pkg::LINE_BYTES'(8'h03);
            cache_pkg::SIZE_W: s_base_mask = cache_pkg::LINE_BYTES'(8'h0f);
            cache_pkg::SIZE_D: s_base_mask = cache_pkg::LINE_BYTES'(8'hff);
            default:           s_base_mask = cache_pkg::LINE_BYTES'(8'h01);
        endcase
    end

    assign o_byte_mask = s_base_mask << i_offset;

    // Every lane of the store width carries the same data.
    always_comb begin
        case (i_size)
            cache_pkg::SIZE_H:
                o_lane_data = {(cache_pkg::LINE_W / 16){i_wdata[15:0]}};
            cache_pkg::SIZE_W:
                o_lane_data = {(cache_pkg::LINE_W / 32){i_wdata[31:0]}};
            cache_pkg::SIZE_D:
                o_lane_data = {(cache_pkg::LINE_W / cache_pkg::REG_W){i_wdata}};
            default:
                o_lane_data = {cache_pkg::LINE_BYTES{i_wdata[7:0]}};
        endcase
    end

endmodule

/* source/tag_store.sv */
`timescale 1ns/1ps

module tag_store #(
    parameter int SET_COUNT = 16,
    localparam int IDX_W = $clog2(SET_COUNT),
    localparam int TAG_W = cache_pkg::ADDR_W - IDX_W - cache_pkg::OFS_W
) (
    input  logic                              clk,
    input  logic                              arstn,
    input  logic [IDX_W-1:0]                  i_index,
    input  logic [TAG_W-1:0]                  i_tag,
    input  logic                              i_store_en,
    input  logic                              i_refill_en,
    input  logic [cache_pkg::WAY_W-1:0]       i_victim_way,
    output logic                              o_hit,
    output logic [cache_pkg::WAY_W-1:0]       o_hit_way,
    output logic                              o_victim_dirty,
    output logic [cache_pkg::ADDR_W-1:0]      o_wb_addr
);

    logic [TAG_W-1:0]           tag_mem [SET_COUNT][cache_pkg::WAYS];
    logic [cache_pkg::WAYS-1:0] valid_q [SET_COUNT];
    logic [cache_pkg::WAYS-1:0] dirty_q [SET_COUNT];

    logic [cache_pkg::WAYS-1:0] s_match;

    // ----------------------------------------
    // Lookup.
    // ----------------------------------------
    always_comb begin
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            s_match[w] = valid_q[i_index][w] & (tag_mem[i_index][w] == i_tag);
        end
    end

    assign o_hit = |s_match;

    // Lowest matching way wins.
    always_comb begin
        o_hit_way = '0;
        for (int w = cache_pkg::WAYS - 1; w >= 0; w--) begin
            if (s_match[w]) begin
                o_hit_way = cache_pkg::WAY_W'(w);
            end
        end
    end

    assign o_victim_dirty = dirty_q[i_index][i_victim_way];
    assign o_wb_addr      = {tag_mem[i_index][i_victim_way], i_index,
                             {cache_pkg::OFS_W{1'b0}}};

    // ----------------------------------------
    // Updates.
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (i_refill_en) begin
            tag_mem[i_index][i_victim_way] <= i_tag;
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (~arstn) begin
            for (int s = 0; s < SET_COUNT; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (i_store_en) begin
            dirty_q[i_index][o_hit_way] <= 1'b1;
        end else if (i_refill_en) begin
            // Fresh line from memory is clean.
            valid_q[i_index][i_victim_way] <= 1'b1;
            dirty_q[i_index][i_victim_way] <= 1'b0;
        end
    end

    store_needs_hit: assert property (
        @(posedge clk) disable iff (~arstn) i_store_en |-> o_hit
    ) else $error("Store issued on a miss.");

endmodule

/* tb/data_cache_tb.sv */
`timescale 1ns/1ps

module data_cache_tb;

    localparam int SET_COUNT    = 16;
    localparam int IDX_W        = $clog2(SET_COUNT);
    localparam int TAG_W        = cache_pkg::ADDR_W - IDX_W - cache_pkg::OFS_W;
    localparam int PERIOD_NS    = 8;
    localparam int RESET_CYCLES = 8;
    // Cycles of the five tests with their closing idle cycles.
    localparam int TEST_CYCLES  = 11 + 18 + 14 + 33 + 11;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + TEST_CYCLES + 4) * PERIOD_NS + 200;

    logic                  clk;
    logic                  arstn;
    cache_pkg::cache_cmd_t cmd;
    logic [63:0]           addr;
    cache_pkg::store_size_e size;
    logic [63:0]           wdata;
    cache_pkg::line_t      line_in;
    logic                  hit;
    logic [63:0]           rdata;
    cache_pkg::line_t      victim_line;
    logic                  victim_dirty;
    logic [63:0]           wb_addr;
    logic                  store_misaligned;

    // Reference model of the cache state.
    logic [TAG_W-1:0] m_tag   [SET_COUNT][cache_pkg::WAYS];
    bit               m_valid [SET_COUNT][cache_pkg::WAYS];
    bit               m_dirty [SET_COUNT][cache_pkg::WAYS];
    int               m_age   [SET_COUNT][cache_pkg::WAYS];
    cache_pkg::line_t m_line  [SET_COUNT][cache_pkg::WAYS];

    logic [63:0] rng_state;
    bit          chk_en;
    string       cur_test;
    int          test_errs;
    int          total_errs;
    int          n_checks;
    int          tests_run;
    int          tests_failed;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clk (
        .clk   (clk),
        .arstn (arstn)
    );

    data_cache #(.SET_COUNT(SET_COUNT)) uut (
        .clk                (clk),
        .arstn              (arstn),
        .i_cmd              (cmd),
        .i_addr             (addr),
        .i_size             (size),
        .i_wdata            (wdata),
        .i_line             (line_in),
        .o_hit              (hit),
        .o_rdata            (rdata),
        .o_victim_line      (victim_line),
        .o_victim_dirty     (victim_dirty),
        .o_wb_addr          (wb_addr),
        .o_store_misaligned (store_misaligned)
    );

    // ----------------------------------------
    // Random numbers and addresses.
    // ----------------------------------------
    function automatic logic [63:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 7;
        rng_state ^= rng_state << 17;
        return rng_state;
    endfunction

    function automatic logic [TAG_W-1:0] random_tag();
        return TAG_W'(next_rand());
    endfunction

    function automatic cache_pkg::line_t random_line();
        cache_pkg::line_t ln;
        logic [63:0]      r;
        for (int i = 0; i < cache_pkg::LINE_WORDS; i++) begin
            r = next_rand();
            ln.words[i] = r[31:0];
        end
        return ln;
    endfunction

    function automatic logic [63:0] make_addr(logic [TAG_W-1:0] tg, int idx, int ofs);
        return {tg, IDX_W'(idx), cache_pkg::OFS_W'(ofs)};
    endfunction

    // ----------------------------------------
    // Reference functions.
    // ----------------------------------------
    function automatic int find_hit_way(int idx, logic [TAG_W-1:0] tg);
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tg) return w;
        end
        return -1;
    endfunction

    function automatic int lru_victim(int idx);
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            if (m_age[idx][w] == 0) return w;
        end
        return 0;
    endfunction

    function automatic logic misalign_rule(cache_pkg::store_size_e sz, logic [5:0] ofs);
        case (sz)
            cache_pkg::SIZE_H: return ofs[0];
            cache_pkg::SIZE_W: return ofs[1] | ofs[0];
            cache_pkg::SIZE_D: return ofs[2] | ofs[1] | ofs[0];
            default:           return 1'b0;
        endcase
    endfunction

    // Little-endian store of 1, 2, 4 or 8 bytes.
    function automatic cache_pkg::line_t apply_store(cache_pkg::line_t ln,
            cache_pkg::store_size_e sz, logic [5:0] ofs, logic [63:0] wd);
        cache_pkg::line_t res;
        int               nbytes;
        res    = ln;
        nbytes = 1 << int'(sz);
        for (int b = 0; b < nbytes; b++) begin
            res.bytes[int'(ofs) + b] = wd[b*8 +: 8];
        end
        return res;
    endfunction

    // Eight bytes from the addressed word, zero past the line end.
    function automatic logic [63:0] read_window(cache_pkg::line_t ln, logic [3:0] w);
        logic [63:0] r;
        r = '0;
        for (int k = 0; k < 8; k++) begin
            if (int'(w) * 4 + k < cache_pkg::LINE_BYTES) begin
                r[k*8 +: 8] = ln.bytes[int'(w) * 4 + k];
            end
        end
        return r;
    endfunction

    // ----------------------------------------
    // Model update and comparison.
    // ----------------------------------------
    always @(posedge clk) begin : update_model
        int               idx;
        int               hw;
        int               vw;
        int               aw;
        logic [TAG_W-1:0] tg;
        if (arstn) begin
            idx = int'(addr[cache_pkg::OFS_W +: IDX_W]);
            tg  = addr[cache_pkg::ADDR_W-1 -: TAG_W];
            hw  = find_hit_way(idx, tg);
            vw  = lru_victim(idx);
            aw  = (hw >= 0) ? hw : vw;
            if (cmd.store_en && hw >= 0) begin
                m_line[idx][hw]  = apply_store(m_line[idx][hw], size, addr[5:0], wdata);
                m_dirty[idx][hw] = 1'b1;
            end else if (cmd.refill_en) begin
                m_line[idx][vw]  = line_in;
                m_tag[idx][vw]   = tg;
                m_valid[idx][vw] = 1'b1;
                m_dirty[idx][vw] = 1'b0;
            end
            if (cmd.touch_en) begin
                for (int w = 0; w < cache_pkg::WAYS; w++) begin
                    if (m_age[idx][w] > m_age[idx][aw]) m_age[idx][w]--;
                end
                m_age[idx][aw] = cache_pkg::WAYS - 1;
            end
        end
    end

    task automatic report_error(input string what, input logic [511:0] exp_v,
                                input logic [511:0] act_v);
        $display("ERR %s %s: expected %0h, actual %0h", cur_test, what, exp_v, act_v);
        test_errs++;
        total_errs++;
    endtask

    always @(negedge clk) begin : compare_outputs
        int               idx;
        int               hw;
        int               vw;
        logic [TAG_W-1:0] tg;
        logic [63:0]      exp_wb;
        logic             exp_mis;
        if (chk_en) begin
            idx     = int'(addr[cache_pkg::OFS_W +: IDX_W]);
            tg      = addr[cache_pkg::ADDR_W-1 -: TAG_W];
            hw      = find_hit_way(idx, tg);
            vw      = lru_victim(idx);
            exp_mis = misalign_rule(size, addr[5:0]);
            n_checks++;
            if (hit !== (hw >= 0)) report_error("o_hit", 512'(hw >= 0), 512'(hit));
            if (store_misaligned !== exp_mis) begin
                report_error("o_store_misaligned", 512'(exp_mis), 512'(store_misaligned));
            end
            if (victim_dirty !== m_dirty[idx][vw]) begin
                report_error("o_victim_dirty", 512'(m_dirty[idx][vw]), 512'(victim_dirty));
            end
            // Tag and data of a never-filled way are unknown.
            if (m_valid[idx][vw]) begin
                exp_wb = {m_tag[idx][vw], IDX_W'(idx), {cache_pkg::OFS_W{1'b0}}};
                if (wb_addr !== exp_wb) report_error("o_wb_addr", 512'(exp_wb), 512'(wb_addr));
                if (victim_line !== m_line[idx][vw]) begin
                    report_error("o_victim_line", m_line[idx][vw], victim_line);
                end
            end
            if (hw >= 0 && rdata !== read_window(m_line[idx][hw], addr[5:2])) begin
                report_error("o_rdata", 512'(read_window(m_line[idx][hw], addr[5:2])),
                             512'(rdata));
            end
        end
    end

    // ----------------------------------------
    // Stimulus.
    // ----------------------------------------
    task automatic drive_cycle(input logic st, input logic rf, input logic tc,
                               input logic [63:0] a, input cache_pkg::store_size_e sz,
                               input logic [63:0] wd, input cache_pkg::line_t ln);
        @(posedge clk);
        #1;
        cmd.store_en  = st;
        cmd.refill_en = rf;
        cmd.touch_en  = tc;
        addr          = a;
        size          = sz;
        wdata         = wd;
        line_in       = ln;
    endtask

    task automatic idle_at(input logic [63:0] a);
        drive_cycle(1'b0, 1'b0, 1'b0, a, cache_pkg::SIZE_B, '0, '0);
    endtask

    task automatic refill_at(input logic [63:0] a, input logic tc);
        drive_cycle(1'b0, 1'b1, tc, a, cache_pkg::SIZE_B, '0, random_line());
    endtask

    task automatic store_at(input logic [63:0] a, input cache_pkg::store_size_e sz,
                            input logic tc);
        drive_cycle(1'b1, 1'b0, tc, a, sz, next_rand(), '0);
    endtask

    task automatic touch_at(input logic [63:0] a);
        drive_cycle(1'b0, 1'b0, 1'b1, a, cache_pkg::SIZE_B, '0, '0);
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        @(posedge clk);
        #1;
        cmd = '0;
        @(negedge clk);
        #1;
        tests_run++;
        if (test_errs != 0) tests_failed++;
        $display("Test %s: %s (%0d errors)", cur_test, (test_errs == 0) ? "pass" : "FAIL",
                 test_errs);
    endtask

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Watchdog expired: the tests did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    initial begin : main
        logic [TAG_W-1:0] t [cache_pkg::WAYS];
        logic [TAG_W-1:0] tg;
        int               ofs;
        rng_state    = 64'd75226;
        cmd          = '0;
        addr         = '0;
        size         = cache_pkg::SIZE_B;
        wdata        = '0;
        line_in      = '0;
        chk_en       = 1'b0;
        total_errs   = 0;
        n_checks     = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int s = 0; s < SET_COUNT; s++) begin
            for (int w = 0; w < cache_pkg::WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_age[s][w]   = w;
            end
        end
        wait (arstn === 1'b1);
        @(posedge clk);
        chk_en = 1'b1;

        start_test("reset_state");
        for (int i = 0; i < 8; i++) idle_at(make_addr(random_tag(), i * 2, 0));
        refill_at(make_addr(random_tag(), 0, 0), 1'b0);
        idle_at(make_addr(random_tag(), 0, 0));
        end_test();

        start_test("refill_readback");
        tg = random_tag();
        refill_at(make_addr(tg, 1, 0), 1'b1);
        for (int w = 0; w < cache_pkg::LINE_WORDS; w++) idle_at(make_addr(tg, 1, w * 4));
        end_test();

        start_test("store_sizes");
        tg = random_tag();
        refill_at(make_addr(tg, 2, 0), 1'b1);
        store_at(make_addr(tg, 2, 5), cache_pkg::SIZE_B, 1'b1);
        idle_at(make_addr(tg, 2, 4));
        store_at(make_addr(tg, 2, 10), cache_pkg::SIZE_H, 1'b1);
        idle_at(make_addr(tg, 2, 8));
        store_at(make_addr(tg, 2, 20), cache_pkg::SIZE_W, 1'b1);
        idle_at(make_addr(tg, 2, 20));
        store_at(make_addr(tg, 2, 40), cache_pkg::SIZE_D, 1'b1);
        idle_at(make_addr(tg, 2, 40));
        // Age the stored way out so it becomes the victim.
        for (int i = 0; i < 3; i++) refill_at(make_addr(random_tag(), 2, 0), 1'b1);
        idle_at(make_addr(random_tag(), 2, 0));
        end_test();

        start_test("misalign_sweep");
        for (int sz = 0; sz < 4; sz++) begin
            for (int wb = 0; wb < 2; wb++) begin
                for (int bo = 0; bo < 4; bo++) begin
                    ofs = int'(next_rand() & 64'd7) * 8 + wb * 4 + bo;
                    drive_cycle(1'b0, 1'b0, 1'b0, make_addr(random_tag(), sz * 4 + wb, ofs),
                                cache_pkg::store_size_e'(sz), '0, '0);
                end
            end
        end
        end_test();

        start_test("lru_replace");
        for (int i = 0; i < cache_pkg::WAYS; i++) begin
            t[i] = random_tag();
            refill_at(make_addr(t[i], 3, 0), 1'b1);
        end
        store_at(make_addr(t[0], 3, 16), cache_pkg::SIZE_D, 1'b0);
        touch_at(make_addr(t[2], 3, 0));
        touch_at(make_addr(t[1], 3, 0));
        idle_at(make_addr(random_tag(), 3, 0));
        refill_at(make_addr(random_tag(), 3, 0), 1'b1);
        idle_at(make_addr(random_tag(), 3, 0));
        end_test();

        chk_en = 1'b0;
        $display("Tests: %0d run, %0d failed; %0d cycles checked, %0d errors",
                 tests_run, tests_failed, n_checks, total_errs);
        if (total_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic arstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a falling edge, away from the DUT's active edge.
    initial begin
        arstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arstn = 1'b1;
    end

endmodule
